/* rtl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	localparam int DATA_W = 32;
	localparam int REG_ADDR_W = 5;
	// low pc bits that the back end carries.
	localparam int PC_W = 8;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLT = 3'd5,
		ALU_SLL = 3'd6,
		ALU_LUI = 3'd7
	} alu_op_e;

	// link selects pc plus 1.
	typedef enum logic [1:0] {
		WB_ALU  = 2'd0,
		WB_MEM  = 2'd1,
		WB_LINK = 2'd2
	} wb_src_e;

	// ######################################
	// stage payloads.
	// ######################################

	typedef struct packed {
		logic reg_write;
		wb_src_e wb_src;
		logic mem_write;
		logic mem_read;
		alu_op_e alu_op;
		logic [REG_ADDR_W-1:0] rd;
		logic [DATA_W-1:0] operand_a;
		logic [DATA_W-1:0] operand_b;
		logic [DATA_W-1:0] store_data;
		logic [31:0] pc;
	} uop_t;

	typedef struct packed {
		logic reg_write;
		wb_src_e wb_src;
		logic mem_write;
		logic mem_read;
		logic [REG_ADDR_W-1:0] rd;
		logic [DATA_W-1:0] store_data;
		logic [DATA_W-1:0] alu_result;
		logic [PC_W-1:0] pc;
	} ex_mem_t;

	typedef struct packed {
		logic reg_write;
		wb_src_e wb_src;
		logic [REG_ADDR_W-1:0] rd;
		logic [DATA_W-1:0] alu_result;
		logic [DATA_W-1:0] read_data;
		logic [PC_W-1:0] pc;
	} mem_wb_t;

endpackage

`default_nettype wire

/* rtl/stage_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module stage_timer #(
	parameter int STAGE_CYCLES = 3
) (
	input logic CLK,
	input logic reset,
	output logic step
);
	localparam int CNT_W = $clog2(STAGE_CYCLES);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(STAGE_CYCLES - 1);

	logic [CNT_W-1:0] count;

	always_ff @(posedge CLK) begin
		if (reset) begin
			count <= '0;
		end else if (count == LAST) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// one cycle in every STAGE_CYCLES.
	assign step = (count == LAST);

	count_in_range: assert property (@(posedge CLK) disable iff (reset) count <= LAST);

endmodule

`default_nettype wire

/* rtl/execute.sv */
`timescale 1ns/1ps
`default_nettype none

module execute import cpu_pkg::*; (
	input logic CLK,
	input logic reset,
	input logic step,
	input uop_t uop,
	input logic uop_valid,
	output ex_mem_t ex_mem,
	output logic ex_valid
);
	logic [DATA_W-1:0] alu_result;
	ex_mem_t ex_next;

	// ######################################
	// alu.
	// ######################################

	always_comb begin
		case (uop.alu_op)
			ALU_ADD: alu_result = uop.operand_a + uop.operand_b;
			ALU_SUB: alu_result = uop.operand_a - uop.operand_b;
			ALU_AND: alu_result = uop.operand_a & uop.operand_b;
			ALU_OR:  alu_result = uop.operand_a | uop.operand_b;
			ALU_XOR: alu_result = uop.operand_a ^ uop.operand_b;
			ALU_SLT: alu_result = DATA_W'($signed(uop.operand_a) < $signed(uop.operand_b));
			ALU_SLL: alu_result = uop.operand_a << uop.operand_b[4:0];
			ALU_LUI: alu_result = uop.operand_b << 16;
			default: alu_result = '0;
		endcase
	end

	// empty slot drops all control.
	always_comb begin
		ex_next.reg_write = uop_valid && uop.reg_write;
		ex_next.wb_src = uop_valid ? uop.wb_src : WB_ALU;
		ex_next.mem_write = uop_valid && uop.mem_write;
		ex_next.mem_read = uop_valid && uop.mem_read;
		ex_next.rd = uop.rd;
		ex_next.store_data = uop.store_data;
		ex_next.alu_result = alu_result;
		ex_next.pc = uop.pc[PC_W-1:0];
	end

	// ######################################
	// execute/memory register.
	// ######################################

	always_ff @(posedge CLK) begin
		if (reset) begin
			ex_mem <= '0;
			ex_valid <= 1'b0;
		end else if (step) begin
			ex_mem <= ex_next;
			ex_valid <= uop_valid;
		end
	end

	no_read_and_write: assert property (@(posedge CLK) disable iff (reset)
		(step && uop_valid) |-> !(uop.mem_read && uop.mem_write));

endmodule

`default_nettype wire

/* rtl/data_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module data_memory import cpu_pkg::*; #(
	parameter int MEM_ADDR_W = 6
) (
	input logic CLK,
	input logic reset,
	input logic [MEM_ADDR_W-1:0] addr,
	input logic [DATA_W-1:0] write_data,
	input logic write_en,
	output logic [DATA_W-1:0] read_data
);
	localparam int DEPTH = 2 ** MEM_ADDR_W;

	logic [DATA_W-1:0] mem [DEPTH];

	// reset zeroes every word.
	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (write_en) begin
			mem[addr] <= write_data;
		end
	end

	// asynchronous read.
	assign read_data = mem[addr];

endmodule

`default_nettype wire

/* rtl/memory_access.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_access import cpu_pkg::*; #(
	parameter int MEM_ADDR_W = 6
) (
	input logic CLK,
	input logic reset,
	input logic step,
	input ex_mem_t ex_mem,
	input logic ex_valid,
	output mem_wb_t mem_wb,
	output logic mem_valid
);
	logic [MEM_ADDR_W-1:0] mem_addr;
	logic [DATA_W-1:0] mem_rdata;
	logic mem_we;

	// word address.
	assign mem_addr = ex_mem.alu_result[MEM_ADDR_W+1:2];
	// store lands on the step edge.
	assign mem_we = step && ex_valid && ex_mem.mem_write;

	data_memory #(
		.MEM_ADDR_W(MEM_ADDR_W)
	) i_dmem (
		.CLK(CLK),
		.reset(reset),
		.addr(mem_addr),
		.write_data(ex_mem.store_data),
		.write_en(mem_we),
		.read_data(mem_rdata)
	);

	// ######################################
	// memory/writeback register.
	// ######################################

	always_ff @(posedge CLK) begin
		if (reset) begin
			mem_wb <= '0;
			mem_valid <= 1'b0;
		end else if (step) begin
			mem_wb.reg_write <= ex_valid && ex_mem.reg_write;
			mem_wb.wb_src <= ex_mem.wb_src;
			mem_wb.rd <= ex_mem.rd;
			mem_wb.alu_result <= ex_mem.alu_result;
			mem_wb.read_data <= ex_mem.mem_read ? mem_rdata : '0;
			mem_wb.pc <= ex_mem.pc;
			mem_valid <= ex_valid;
		end
	end

	aligned_access: assert property (@(posedge CLK) disable iff (reset)
		(step && ex_valid && (ex_mem.mem_read || ex_mem.mem_write))
		|-> (ex_mem.alu_result[1:0] == 2'b00));

endmodule

`default_nettype wire

/* rtl/writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback import cpu_pkg::*; (
	input logic CLK,
	input logic reset,
	input logic step,
	input mem_wb_t mem_wb,
	input logic mem_valid,
	output logic wb_valid,
	output logic [REG_ADDR_W-1:0] wb_rd,
	output logic [DATA_W-1:0] wb_data
);
	logic [PC_W-1:0] link_pc;
	logic [DATA_W-1:0] wb_sel;

	// pc plus 1 wraps inside PC_W bits.
	assign link_pc = mem_wb.pc + 1'b1;

	always_comb begin
		case (mem_wb.wb_src)
			WB_MEM:  wb_sel = mem_wb.read_data;
			WB_LINK: wb_sel = DATA_W'(link_pc);
			default: wb_sel = mem_wb.alu_result;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			wb_valid <= 1'b0;
			wb_rd <= '0;
			wb_data <= '0;
		end else begin
			// single cycle pulse.
			wb_valid <= step && mem_valid && mem_wb.reg_write;
			if (step) begin
				wb_rd <= mem_wb.rd;
				wb_data <= wb_sel;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/backend_top.sv */
`timescale 1ns/1ps
`default_nettype none

module backend_top import cpu_pkg::*; #(
	parameter int STAGE_CYCLES = 3,
	parameter int MEM_ADDR_W = 6
) (
	input logic CLK,
	input logic reset,
	input uop_t uop,
	input logic uop_valid,
	output logic issue_step,
	output logic wb_valid,
	output logic [REG_ADDR_W-1:0] wb_rd,
	output logic [DATA_W-1:0] wb_data
);
	ex_mem_t ex_mem;
	logic ex_valid;
	mem_wb_t mem_wb;
	logic mem_valid;

	// issue_step is the shared step net.
	stage_timer #(
		.STAGE_CYCLES(STAGE_CYCLES)
	) i_timer (
		.CLK(CLK),
		.reset(reset),
		.step(issue_step)
	);

	execute i_execute (
		.CLK(CLK),
		.reset(reset),
		.step(issue_step),
		.uop(uop),
		.uop_valid(uop_valid),
		.ex_mem(ex_mem),
		.ex_valid(ex_valid)
	);

	memory_access #(
		.MEM_ADDR_W(MEM_ADDR_W)
	) i_memory (
		.CLK(CLK),
		.reset(reset),
		.step(issue_step),
		.ex_mem(ex_mem),
		.ex_valid(ex_valid),
		.mem_wb(mem_wb),
		.mem_valid(mem_valid)
	);

	writeback i_writeback (
		.CLK(CLK),
		.reset(reset),
		.step(issue_step),
		.mem_wb(mem_wb),
		.mem_valid(mem_valid),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

endmodule

`default_nettype wire

/* test/tb_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_backend import cpu_pkg::*; ();

	localparam int STAGE_CYCLES = 3;
	localparam int MEM_ADDR_W = 6;
	localparam int NUM_SLOTS = 200;
	localparam int CYCLE_LIMIT = NUM_SLOTS * STAGE_CYCLES + 100;

	typedef struct packed {
		logic [REG_ADDR_W-1:0] rd;
		logic [DATA_W-1:0] data;
		logic [31:0] due_step;
	} wb_entry_t;

	logic CLK;
	logic reset;
	uop_t uop;
	logic uop_valid;
	logic issue_step;
	logic wb_valid;
	logic [REG_ADDR_W-1:0] wb_rd;
	logic [DATA_W-1:0] wb_data;

	logic [31:0] lcg_state = 32'd43;
	logic [DATA_W-1:0] model_mem [2**MEM_ADDR_W];
	wb_entry_t expected_q [$];
	wb_entry_t seen;
	logic [31:0] step_count = '0;
	logic after_step = 1'b0;
	logic expect_wb;
	int since_reset = 0;
	int cycle_count = 0;

	backend_top #(
		.STAGE_CYCLES(STAGE_CYCLES),
		.MEM_ADDR_W(MEM_ADDR_W)
	) i_dut (
		.CLK(CLK),
		.reset(reset),
		.uop(uop),
		.uop_valid(uop_valid),
		.issue_step(issue_step),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// ######################################
	// helpers.
	// ######################################

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_issue_step(input logic expected, input logic actual);
		if (actual !== expected) begin
			stop_on_error($sformatf("Mismatch issue_step: expected %h, got %h",
				expected, actual));
		end
	endtask

	task automatic check_wb_valid(input logic expected, input logic actual);
		if (actual !== expected) begin
			stop_on_error($sformatf("Mismatch wb_valid: expected %h, got %h",
				expected, actual));
		end
	endtask

	task automatic check_wb_rd(input logic [REG_ADDR_W-1:0] expected,
		input logic [REG_ADDR_W-1:0] actual);
		if (actual !== expected) begin
			stop_on_error($sformatf("Mismatch wb_rd: expected %h, got %h", expected, actual));
		end
	endtask

	task automatic check_wb_data(input logic [DATA_W-1:0] expected,
		input logic [DATA_W-1:0] actual);
		if (actual !== expected) begin
			stop_on_error($sformatf("Mismatch wb_data: expected %h, got %h", expected, actual));
		end
	endtask

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// low lcg bits are weak, so take the upper halves.
	function automatic logic [31:0] rand32();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = next_rand();
		lo = next_rand();
		return {hi[31:16], lo[31:16]};
	endfunction

	function automatic logic [DATA_W-1:0] alu_model(input alu_op_e op,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR:  return a | b;
			ALU_XOR: return a ^ b;
			ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ALU_SLL: return a << b[4:0];
			default: return b << 16;
		endcase
	endfunction

	task automatic build_uop(output uop_t u, output logic v);
		logic [31:0] r;
		logic [5:0] idx;
		r = next_rand();
		u = '0;
		v = 1'b1;
		u.reg_write = 1'b1;
		u.wb_src = WB_ALU;
		u.alu_op = alu_op_e'(r[22:20]);
		u.rd = r[27:23];
		u.operand_a = rand32();
		u.operand_b = rand32();
		u.store_data = rand32();
		u.pc = rand32();
		case (r[18:16])
			3'd4: begin
				// stores stay in the low 16 words.
				idx = {2'b00, r[31:28]};
				u.alu_op = ALU_ADD;
				u.reg_write = 1'b0;
				u.mem_write = 1'b1;
				u.operand_a = {u.operand_a[31:8], idx, 2'b00};
				u.operand_b = {u.operand_b[31:8], 8'h00};
			end
			3'd5: begin
				idx = {1'b0, r[31:27]};
				u.alu_op = ALU_ADD;
				u.mem_read = 1'b1;
				u.wb_src = WB_MEM;
				u.operand_a = {u.operand_a[31:8], idx, 2'b00};
				u.operand_b = {u.operand_b[31:8], 8'h00};
			end
			3'd6: u.wb_src = WB_LINK;
			3'd7: begin
				// empty slot with live looking control.
				v = 1'b0;
				u.mem_write = r[30];
			end
			default: begin
				if (r[31:29] == 3'd0) begin
					u.reg_write = 1'b0;
				end
			end
		endcase
	endtask

	task automatic model_issue(input uop_t u, input logic v, input logic [31:0] at_step);
		logic [DATA_W-1:0] result;
		logic [MEM_ADDR_W-1:0] idx;
		logic [PC_W-1:0] next_pc;
		wb_entry_t e;
		if (v) begin
			result = alu_model(u.alu_op, u.operand_a, u.operand_b);
			idx = result[MEM_ADDR_W+1:2];
			if (u.mem_write) begin
				model_mem[idx] = u.store_data;
			end
			if (u.reg_write) begin
				e.rd = u.rd;
				e.due_step = at_step + 2;
				next_pc = u.pc[PC_W-1:0] + 1'b1;
				case (u.wb_src)
					WB_MEM:  e.data = model_mem[idx];
					WB_LINK: e.data = {{(DATA_W-PC_W){1'b0}}, next_pc};
					default: e.data = result;
				endcase
				expected_q.push_back(e);
			end
		end
	endtask

	task automatic wait_step_cycle();
		do begin
			@(posedge CLK);
			#2;
		end while (issue_step !== 1'b1);
	endtask

	// ######################################
	// stimulus.
	// ######################################

	initial begin
		uop_t u;
		logic v;
		for (int i = 0; i < 2**MEM_ADDR_W; i++) begin
			model_mem[i] = '0;
		end
		uop = '0;
		uop_valid = 1'b0;
		reset = 1'b1;
		repeat (10) @(posedge CLK);
		#2;
		reset = 1'b0;
		for (int n = 0; n < NUM_SLOTS; n++) begin
			wait_step_cycle();
			build_uop(u, v);
			uop = u;
			uop_valid = v;
			// sampled at the coming step edge.
			model_issue(u, v, step_count + 1);
		end
		wait_step_cycle();
		uop = '0;
		uop_valid = 1'b0;
		while (expected_q.size() != 0) begin
			@(posedge CLK);
		end
		repeat (4 * STAGE_CYCLES) @(posedge CLK);
		$display("TESTBENCH PASSED");
		$finish;
	end

	// ######################################
	// writeback monitor.
	// ######################################

	always @(negedge CLK) begin
		if (reset === 1'b1) begin
			check_wb_valid(1'b0, wb_valid);
			check_issue_step(1'b0, issue_step);
			after_step = 1'b0;
			since_reset = 0;
		end else begin
			// step every STAGE_CYCLES cycles from release.
			since_reset = since_reset + 1;
			check_issue_step((since_reset % STAGE_CYCLES) == 0, issue_step);
			expect_wb = after_step && (expected_q.size() != 0)
				&& (expected_q[0].due_step == step_count);
			if (wb_valid === 1'b1 && expected_q.size() == 0) begin
				stop_on_error("wb_valid went high with no writeback expected");
			end
			check_wb_valid(expect_wb, wb_valid);
			if (expect_wb) begin
				seen = expected_q.pop_front();
				check_wb_rd(seen.rd, wb_rd);
				check_wb_data(seen.data, wb_data);
			end
			after_step = (issue_step === 1'b1);
			if (after_step) begin
				step_count = step_count + 1;
			end
		end
	end

	initial begin
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge CLK);
			cycle_count++;
		end
		$display("run did not finish within %0d cycles", cycle_count);
		$display("TESTBENCH FAILED");
		$fatal(1, "cycle limit reached");
	end

endmodule

`default_nettype wire

/* build.f */
rtl/cpu_pkg.sv
rtl/stage_timer.sv
rtl/execute.sv
rtl/data_memory.sv
rtl/memory_access.sv
rtl/writeback.sv
rtl/backend_top.sv
test/tb_backend.sv

/* Makefile */
VERILATOR := verilator
FLAGS := --binary --timing --assert -j 0
TOP := tb_backend
FILELIST := build.f
OBJ_DIR := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
